// ==== Makefile ====
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_usb_fs_rx
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+.
usb_rx_pkg.sv
usb_rx_line_recovery.sv
usb_rx_bit_decode.sv
usb_rx_crc_check.sv
usb_rx_packet.sv
usb_fs_rx.sv
usb_fs_rx_chk.sv
tb_usb_fs_rx.sv

// ==== tb_usb_fs_rx.sv ====
// testbench for the full-speed USB receiver
// encodes packets onto D+/D-, predicts every byte and verdict, and compares them at pkt_end_o
`include "usb_rx_consts.svh"

module tb_usb_fs_rx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] SYM_SE0 = 2'b00;
  localparam logic [1:0] SYM_K   = 2'b01;
  localparam logic [1:0] SYM_J   = 2'b10;

  // what one packet should produce at its end
  typedef struct packed {
    logic [3:0] pid;
    logic [6:0] addr;
    logic [3:0] endp;
    logic       chk_all;
    logic       chk_tok;
    logic       valid;
    logic       crc5;
    logic       crc16;
    logic       piderr;
    logic       stuff;
    int         byte_mark;
  } exp_t;

  logic clk_i;
  logic rst_ni;
  logic usb_dp;
  logic usb_dn;
  logic pkt_start;
  logic pkt_end;
  usb_rx_pkg::pid_e pid;
  logic [6:0] addr;
  logic [3:0] endp;
  logic rx_data_put;
  logic [7:0] rx_data;
  logic valid_pid;
  logic valid_packet;
  logic crc5_error;
  logic crc16_error;
  logic pid_error;
  logic bitstuff_error;

  logic [31:0] lcg_state = 32'ha9f2_ae28;
  logic        tx_bits[$];
  logic [1:0]  sym_q[$];
  logic [7:0]  exp_bytes[$];
  exp_t        exp_q[$];
  exp_t        cur;
  logic        pkt_open = 1'b0;
  int          byte_total = 0;
  int          bytes_seen = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  usb_fs_rx u_usb_fs_rx (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .usb_dp_i         (usb_dp),
    .usb_dn_i         (usb_dn),
    .pkt_start_o      (pkt_start),
    .pkt_end_o        (pkt_end),
    .pid_o            (pid),
    .addr_o           (addr),
    .endp_o           (endp),
    .rx_data_put_o    (rx_data_put),
    .rx_data_o        (rx_data),
    .valid_pid_o      (valid_pid),
    .valid_packet_o   (valid_packet),
    .crc5_error_o     (crc5_error),
    .crc16_error_o    (crc16_error),
    .pid_error_o      (pid_error),
    .bitstuff_error_o (bitstuff_error)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[30:23];
  endfunction

  // CRC over tx_bits from index first, returned already complemented
  function automatic logic [15:0] ref_crc(input int first, input int width);
    logic [15:0] crc;
    logic [15:0] poly;
    logic        fb;
    crc  = 16'hffff;
    poly = (width == 5) ? 16'(`USB_RX_CRC5_POLY) : 16'(`USB_RX_CRC16_POLY);
    for (int i = first; i < tx_bits.size(); i++) begin
      fb  = tx_bits[i] ^ crc[width-1];
      crc = (crc << 1) ^ (fb ? poly : 16'h0000);
    end
    return ~crc & ((16'h1 << width) - 16'h1);
  endfunction

  task automatic push_byte(input logic [7:0] b);
    for (int i = 0; i < 8; i++) tx_bits.push_back(b[i]);
  endtask

  // the CRC goes out highest-order bit first, flip corrupts its first bit
  task automatic append_crc(input int width, input logic flip);
    logic [15:0] crc;
    crc = ref_crc(8, width);
    for (int i = width - 1; i >= 0; i--) begin
      tx_bits.push_back(crc[i] ^ (flip && (i == width - 1)));
    end
  endtask

  // idle, sync, NRZI data with optional stuffing, two SE0 bits and J
  task automatic encode_line(input logic stuff_en);
    logic [1:0] lvl;
    int         ones;
    repeat (4) sym_q.push_back(SYM_J);
    repeat (3) begin
      sym_q.push_back(SYM_K);
      sym_q.push_back(SYM_J);
    end
    sym_q.push_back(SYM_K);
    sym_q.push_back(SYM_K);
    lvl  = SYM_K;
    ones = 0;
    foreach (tx_bits[i]) begin
      if (!tx_bits[i]) lvl = ~lvl;
      sym_q.push_back(lvl);
      ones = tx_bits[i] ? ones + 1 : 0;
      if (stuff_en && ones == `USB_RX_MAX_ONES) begin
        lvl = ~lvl;
        sym_q.push_back(lvl);
        ones = 0;
      end
    end
    sym_q.push_back(SYM_SE0);
    sym_q.push_back(SYM_SE0);
    sym_q.push_back(SYM_J);
  endtask

  task automatic send_token(input logic [3:0] p, input logic flip);
    logic [7:0] r;
    exp_t       e;
    e = '0;
    tx_bits.delete();
    push_byte({~p, p});
    r = rand_byte();
    e.addr = r[6:0];
    r = rand_byte();
    e.endp = r[3:0];
    for (int i = 0; i < 7; i++) tx_bits.push_back(e.addr[i]);
    for (int i = 0; i < 4; i++) tx_bits.push_back(e.endp[i]);
    append_crc(5, flip);
    e.pid = p;
    e.chk_all = 1'b1;
    e.chk_tok = 1'b1;
    e.valid = !flip;
    e.crc5 = flip;
    e.byte_mark = byte_total;
    exp_q.push_back(e);
    encode_line(1'b1);
  endtask

  // two 0xFF bytes at ff_at force stuffed bits, the CRC bytes come out as data too
  task automatic send_data(input logic [3:0] p, input int nbytes, input int ff_at,
                           input logic flip);
    logic [7:0] b;
    exp_t       e;
    e = '0;
    tx_bits.delete();
    push_byte({~p, p});
    for (int k = 0; k < nbytes; k++) begin
      push_byte((k == ff_at || k == ff_at + 1) ? 8'hff : rand_byte());
    end
    append_crc(16, flip);
    for (int i = 8; i + 7 < tx_bits.size(); i += 8) begin
      for (int j = 0; j < 8; j++) b[j] = tx_bits[i+j];
      exp_bytes.push_back(b);
      byte_total++;
    end
    e.pid = p;
    e.chk_all = 1'b1;
    e.valid = !flip;
    e.crc16 = flip;
    e.byte_mark = byte_total;
    exp_q.push_back(e);
    encode_line(1'b1);
  endtask

  task automatic send_handshake(input logic [3:0] p);
    exp_t e;
    e = '0;
    tx_bits.delete();
    push_byte({~p, p});
    e.pid = p;
    e.chk_all = 1'b1;
    e.valid = 1'b1;
    e.byte_mark = byte_total;
    exp_q.push_back(e);
    encode_line(1'b1);
  endtask

  // malformed packets, only the verdict and the one error flag are predicted
  task automatic send_bad(input logic [7:0] pid_byte, input int ones, input logic stuff_en);
    exp_t e;
    e = '0;
    tx_bits.delete();
    push_byte(pid_byte);
    repeat (ones) tx_bits.push_back(1'b1);
    e.piderr = (pid_byte[3:0] != ~pid_byte[7:4]);
    e.stuff = !stuff_en;
    e.byte_mark = byte_total;
    exp_q.push_back(e);
    encode_line(stuff_en);
  endtask

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
  endtask

  //////////////////////////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && pkt_start) begin
      assert (!pkt_open) else begin
        flag_error("start of packet while the previous packet is still open");
        $fatal(1);
      end
      pkt_open = 1'b1;
    end
    if (rst_ni && rx_data_put) begin
      assert (exp_bytes.size() != 0) else begin
        flag_error($sformatf("unexpected data byte %02h", rx_data));
        $fatal(1);
      end
      assert (rx_data == exp_bytes[0]) else begin
        flag_error($sformatf("data byte %02h, expected %02h", rx_data, exp_bytes[0]));
        $fatal(1);
      end
      void'(exp_bytes.pop_front());
      bytes_seen++;
    end
    if (rst_ni && pkt_end) begin
      assert (exp_q.size() != 0) else begin
        flag_error("end of packet with no packet outstanding");
        $fatal(1);
      end
      assert (pkt_open) else begin
        flag_error("end of packet without a start of packet");
        $fatal(1);
      end
      pkt_open = 1'b0;
      cur = exp_q.pop_front();
      assert (bytes_seen == cur.byte_mark) else begin
        flag_error($sformatf("%0d bytes seen, expected %0d", bytes_seen, cur.byte_mark));
        $fatal(1);
      end
      assert (valid_packet == cur.valid) else begin
        flag_error($sformatf("valid_packet %0b, expected %0b", valid_packet, cur.valid));
        $fatal(1);
      end
      if (cur.chk_all) begin
        assert (pid == cur.pid && valid_pid) else begin
          flag_error($sformatf("pid %h valid %0b, expected %h", pid, valid_pid, cur.pid));
          $fatal(1);
        end
        assert ({crc5_error, crc16_error, pid_error, bitstuff_error} ==
                {cur.crc5, cur.crc16, 2'b00}) else begin
          flag_error($sformatf("error flags %b%b%b%b, expected %b%b00", crc5_error,
                               crc16_error, pid_error, bitstuff_error, cur.crc5, cur.crc16));
          $fatal(1);
        end
        if (cur.chk_tok) begin
          assert (addr == cur.addr && endp == cur.endp) else begin
            flag_error($sformatf("addr %h endp %h, expected %h %h", addr, endp,
                                 cur.addr, cur.endp));
            $fatal(1);
          end
        end
      end else begin
        assert (!cur.piderr || (pid_error && !valid_pid)) else begin
          flag_error("bad PID not flagged");
          $fatal(1);
        end
        assert (!cur.stuff || bitstuff_error) else begin
          flag_error("seven ones not flagged as a stuffing error");
          $fatal(1);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("run timed out after %0d cycles with packets still outstanding", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  initial begin
    rst_ni = 1'b0;
    {usb_dp, usb_dn} = SYM_J;
    send_token(usb_rx_pkg::PID_OUT, 1'b0);
    send_data(usb_rx_pkg::PID_DATA0, 6, 2, 1'b0);
    send_token(usb_rx_pkg::PID_IN, 1'b1);
    send_data(usb_rx_pkg::PID_DATA1, 4, 0, 1'b1);
    send_bad(8'h01, 0, 1'b1);
    send_bad(8'hc3, 7, 1'b0);
    send_handshake(usb_rx_pkg::PID_ACK);
    cycle_limit = 2 * sym_q.size() * `USB_RX_SAMPLES_PER_BIT + 200;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    foreach (sym_q[i]) begin
      @(posedge clk_i);
      #1 {usb_dp, usb_dn} = sym_q[i];
      repeat (3) @(posedge clk_i);
    end
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    if (exp_bytes.size() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("%0d expected data bytes never arrived", exp_bytes.size());
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== usb_fs_rx.sv ====
// full-speed USB packet receiver working from a D+/D- pair sampled at 48 MHz
// chains line recovery, bit decoding and the packet layer with no back-pressure
module usb_fs_rx (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             usb_dp_i,
  input  logic             usb_dn_i,
  output logic             pkt_start_o,
  output logic             pkt_end_o,
  output usb_rx_pkg::pid_e pid_o,
  output logic [6:0]       addr_o,
  output logic [3:0]       endp_o,
  output logic             rx_data_put_o,
  output logic [7:0]       rx_data_o,
  output logic             valid_pid_o,
  output logic             valid_packet_o,
  output logic             crc5_error_o,
  output logic             crc16_error_o,
  output logic             pid_error_o,
  output logic             bitstuff_error_o
);

  usb_rx_pkg::line_state_e line_state;
  logic                    sample_valid;
  logic                    bit_valid;
  logic                    bit_data;
  logic                    pid_start;
  logic                    stuff_err;

  usb_rx_line_recovery u_line_recovery (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .usb_dp_i       (usb_dp_i),
    .usb_dn_i       (usb_dn_i),
    .line_state_o   (line_state),
    .sample_valid_o (sample_valid)
  );

  // pkt_start_o reports the SOP on the line, the PID start stays internal
  usb_rx_bit_decode u_bit_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .line_state_i   (line_state),
    .sample_valid_i (sample_valid),
    .bit_valid_o    (bit_valid),
    .bit_data_o     (bit_data),
    .pkt_start_o    (pid_start),
    .pkt_end_o      (pkt_end_o),
    .sop_o          (pkt_start_o),
    .stuff_err_o    (stuff_err)
  );

  usb_rx_packet u_packet (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bit_valid_i      (bit_valid),
    .bit_data_i       (bit_data),
    .pkt_start_i      (pid_start),
    .pkt_end_i        (pkt_end_o),
    .stuff_err_i      (stuff_err),
    .pid_o            (pid_o),
    .addr_o           (addr_o),
    .endp_o           (endp_o),
    .rx_data_put_o    (rx_data_put_o),
    .rx_data_o        (rx_data_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

endmodule

// ==== usb_fs_rx_chk.sv ====
// protocol assertions on the receiver's top-level outputs
// bound into every instance of usb_fs_rx
module usb_fs_rx_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic pkt_start_i,
  input logic pkt_end_i,
  input logic rx_data_put_i,
  input logic valid_packet_i,
  input logic crc5_error_i,
  input logic crc16_error_i,
  input logic pid_error_i,
  input logic bitstuff_error_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic       any_error;
  logic [5:0] put_gap_q;

  assign any_error = crc5_error_i | crc16_error_i | pid_error_i | bitstuff_error_i;

  // cycles since the last data byte strobe, saturating at the top
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_gap_q <= '1;
    end else if (rx_data_put_i) begin
      put_gap_q <= '0;
    end else if (put_gap_q != '1) begin
      put_gap_q <= put_gap_q + 6'd1;
    end
  end

  // a new SOP can only be seen once the previous packet has closed
  a_start_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pkt_start_i && pkt_end_i))
    else $error("start and end of packet reported in the same cycle");

  // error outputs are verdicts in the end cycle, and a flagged packet is never valid
  a_err_at_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_error |-> (pkt_end_i && !valid_packet_i))
    else $error("error pulse outside the end of packet cycle or on a valid packet");

  // a byte takes eight bit times of four clocks, so strobes are at least 32 cycles apart
  a_put_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_data_put_i |-> (put_gap_q >= 6'd31))
    else $error("data byte strobes closer than eight bit times");

endmodule

bind usb_fs_rx usb_fs_rx_chk u_chk (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .pkt_start_i      (pkt_start_o),
  .pkt_end_i        (pkt_end_o),
  .rx_data_put_i    (rx_data_put_o),
  .valid_packet_i   (valid_packet_o),
  .crc5_error_i     (crc5_error_o),
  .crc16_error_i    (crc16_error_o),
  .pid_error_i      (pid_error_o),
  .bitstuff_error_i (bitstuff_error_o)
);

// ==== usb_rx_bit_decode.sv ====
// packet framing and bit decoding on the sampled line symbols
// finds sync and EOP, undoes NRZI and bit stuffing, and flags stuffing errors
`include "usb_rx_consts.svh"

module usb_rx_bit_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  usb_rx_pkg::line_state_e line_state_i,
  input  logic                    sample_valid_i,
  output logic                    bit_valid_o,
  output logic                    bit_data_o,
  output logic                    pkt_start_o,
  output logic                    pkt_end_o,
  output logic                    sop_o,
  output logic                    stuff_err_o
);

  localparam int SYM_W  = `USB_RX_SYM_W;
  localparam int HIST_W = `USB_RX_HIST_W;
  localparam int ONES_W = `USB_RX_MAX_ONES + 1;

  // line symbols reduced to the pair encoding of line_state_e
  localparam logic [SYM_W-1:0]  SYM_J   = SYM_W'(usb_rx_pkg::DJ);
  localparam logic [SYM_W-1:0]  SYM_K   = SYM_W'(usb_rx_pkg::DK);
  localparam logic [SYM_W-1:0]  SYM_SE0 = SYM_W'(usb_rx_pkg::SE0);
  localparam logic [HIST_W-1:0] ALL_K   = {(HIST_W / SYM_W){SYM_K}};

  logic [HIST_W-1:0] hist_q;
  logic [HIST_W-1:0] hist_d;
  logic              in_pkt_q;
  logic              in_pkt_d;
  logic              pkt_valid_q;
  logic              pkt_valid_d;
  logic [ONES_W-1:0] ones_q;
  logic [ONES_W-1:0] ones_d;
  logic              stuff_err_q;
  logic              stuff_err_d;
  logic              see_sop;
  logic              see_eop;
  logic [SYM_W-1:0]  sym_prev;
  logic [SYM_W-1:0]  sym_cur;
  logic              raw_valid;
  logic              raw_bit;
  logic              stuff_set;

  //////////////////////////////////////////////////////////////////////
  // framing
  //////////////////////////////////////////////////////////////////////

  // the newest symbol sits in the low bits
  assign hist_d   = sample_valid_i ? {hist_q[HIST_W-SYM_W-1:0], line_state_i[SYM_W-1:0]} : hist_q;
  assign sym_prev = hist_q[2*SYM_W-1:SYM_W];
  assign sym_cur  = hist_q[SYM_W-1:0];

  // SOP is an idle J turning into K, EOP is two sampled SE0 bits
  assign see_sop  = (sym_prev == SYM_J) && (sym_cur == SYM_K) && !in_pkt_q;
  assign see_eop  = (sym_prev == SYM_SE0) && (sym_cur == SYM_SE0);
  assign in_pkt_d = see_eop ? 1'b0 : (see_sop ? 1'b1 : in_pkt_q);

  // the PID stream is open from the end of sync until EOP, and a
  // stuffing error closes it at once
  always_comb begin
    pkt_valid_d = pkt_valid_q;
    if (pkt_valid_q && stuff_err_q) begin
      pkt_valid_d = 1'b0;
    end else if (sample_valid_i) begin
      if (!pkt_valid_q && (hist_q == `USB_RX_SYNC_PATTERN)) begin
        pkt_valid_d = 1'b1;
      end else if (pkt_valid_q && see_eop) begin
        pkt_valid_d = 1'b0;
      end
    end
  end

  assign pkt_start_o = pkt_valid_d && !pkt_valid_q;
  assign pkt_end_o   = !pkt_valid_d && pkt_valid_q;

  //////////////////////////////////////////////////////////////////////
  // NRZI and bit stuffing
  //////////////////////////////////////////////////////////////////////

  // a pair of J/K symbols decodes to one bit, no change on the line is a one
  assign raw_valid = pkt_valid_q && sample_valid_i &&
                     ((sym_prev == SYM_J) || (sym_prev == SYM_K)) &&
                     ((sym_cur == SYM_J) || (sym_cur == SYM_K));
  assign raw_bit   = (sym_prev == sym_cur);

  always_comb begin
    ones_d = ones_q;
    if (pkt_end_o) begin
      ones_d = '0;
    end else if (raw_valid) begin
      ones_d = {ones_q[ONES_W-2:0], raw_bit};
    end
  end

  // a bit that follows six ones is the stuffed zero and is dropped,
  // if it is a one instead the packet is corrupt
  assign stuff_set = raw_valid && (&ones_d);

  always_comb begin
    stuff_err_d = stuff_err_q;
    if (pkt_start_o) begin
      stuff_err_d = 1'b0;
    end else if (stuff_set) begin
      stuff_err_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q      <= ALL_K;
      in_pkt_q    <= 1'b0;
      pkt_valid_q <= 1'b0;
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
    end else begin
      hist_q      <= hist_d;
      in_pkt_q    <= in_pkt_d;
      pkt_valid_q <= pkt_valid_d;
      ones_q      <= ones_d;
      stuff_err_q <= stuff_err_d;
    end
  end

  assign bit_valid_o = raw_valid && !(&ones_q[ONES_W-2:0]);
  assign bit_data_o  = raw_bit;
  assign sop_o       = see_sop;
  assign stuff_err_o = stuff_err_q;

endmodule

// ==== usb_rx_consts.svh ====
// shared constants of the full-speed USB receiver
// include this in any RTL file that needs a width, a line pattern or a CRC value
`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// one line symbol is the D+/D- pair, J is 2'b10 and K is 2'b01
`define USB_RX_SYM_W 2

// six symbols of line history, just enough to see the tail of sync
`define USB_RX_HIST_W 12

// last six sync symbols KJKJKK with the oldest symbol in the top bits
`define USB_RX_SYNC_PATTERN 12'b01_10_01_10_01_01

// CRC5 for tokens is x^5 + x^2 + 1, a good packet leaves 01100 behind
`define USB_RX_CRC5_POLY 5'b00101
`define USB_RX_CRC5_RESIDUE 5'b01100

// CRC16 for data is x^16 + x^15 + x^2 + 1, with its own fixed residue
`define USB_RX_CRC16_POLY 16'h8005
`define USB_RX_CRC16_RESIDUE 16'h800d

// both CRC registers start from all ones
`define USB_RX_CRC_SEED_ONES '1

// after this many ones the transmitter inserts a zero
`define USB_RX_MAX_ONES 6
`define USB_RX_SAMPLES_PER_BIT 4

`endif

// ==== usb_rx_crc_check.sv ====
// serial CRC checker over a bit stream, least significant bit first
// the CRC type sets the width, so one module serves both CRC5 and CRC16
`include "usb_rx_consts.svh"

module usb_rx_crc_check #(
  parameter type  crc_t   = usb_rx_pkg::crc5_t,
  parameter crc_t POLY    = '0,
  parameter crc_t RESIDUE = '0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic init_i,
  input  logic bit_valid_i,
  input  logic bit_data_i,
  output logic residue_ok_o
);

  localparam int W = $bits(crc_t);

  crc_t crc_q;
  crc_t crc_d;
  logic feedback;

  // the polynomial is folded in when the new bit differs from the top bit
  assign feedback = bit_data_i ^ crc_q[W-1];

  always_comb begin
    crc_d = crc_q;
    if (init_i) begin
      crc_d = `USB_RX_CRC_SEED_ONES;
    end else if (bit_valid_i) begin
      crc_d = {crc_q[W-2:0], 1'b0} ^ ({W{feedback}} & POLY);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= `USB_RX_CRC_SEED_ONES;
    end else begin
      crc_q <= crc_d;
    end
  end

  // running the received CRC through the register leaves a fixed residue
  assign residue_ok_o = (crc_q == RESIDUE);

endmodule

// ==== usb_rx_line_recovery.sv ====
// line state and bit clock recovery from a D+/D- pair already synchronous to clk_i
// line_state_o is the settled symbol and sample_valid_o marks one mid-bit sample per bit
`include "usb_rx_consts.svh"

module usb_rx_line_recovery (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    usb_dp_i,
  input  logic                    usb_dn_i,
  output usb_rx_pkg::line_state_e line_state_o,
  output logic                    sample_valid_o
);

  localparam int PHASE_W = $clog2(`USB_RX_SAMPLES_PER_BIT);

  usb_rx_pkg::line_state_e state_q;
  usb_rx_pkg::line_state_e state_d;
  logic [PHASE_W-1:0]      phase_q;
  logic [PHASE_W-1:0]      phase_d;
  logic [1:0]              pair;

  assign pair = {usb_dp_i, usb_dn_i};

  //////////////////////////////////////////////////////////////////////
  // transition filter
  //////////////////////////////////////////////////////////////////////

  // D+ and D- may not flip on the same clock, so any change parks the
  // state in DT for one cycle and the pair is decoded only after that
  always_comb begin
    state_d = state_q;
    if (state_q == usb_rx_pkg::DT) begin
      state_d = usb_rx_pkg::line_state_e'({1'b0, pair});
    end else if (pair != state_q[1:0]) begin
      state_d = usb_rx_pkg::DT;
    end
  end

  // every DT is an edge of the transmitter's bit clock, so the phase
  // restarts there and phase 1 lands in the middle of the bit
  assign phase_d = (state_q == usb_rx_pkg::DT) ? '0 : phase_q + PHASE_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= usb_rx_pkg::SE0;
      phase_q <= '0;
    end else begin
      state_q <= state_d;
      phase_q <= phase_d;
    end
  end

  assign line_state_o   = state_q;
  assign sample_valid_o = (phase_q == PHASE_W'(1));

endmodule

// ==== usb_rx_packet.sv ====
// packet layer of the receiver, fed with unstuffed bits
// captures the PID, token fields and data bytes, and judges each packet at its end
`include "usb_rx_consts.svh"

module usb_rx_packet (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             bit_valid_i,
  input  logic             bit_data_i,
  input  logic             pkt_start_i,
  input  logic             pkt_end_i,
  input  logic             stuff_err_i,
  output usb_rx_pkg::pid_e pid_o,
  output logic [6:0]       addr_o,
  output logic [3:0]       endp_o,
  output logic             rx_data_put_o,
  output logic [7:0]       rx_data_o,
  output logic             valid_pid_o,
  output logic             valid_packet_o,
  output logic             crc5_error_o,
  output logic             crc16_error_o,
  output logic             pid_error_o,
  output logic             bitstuff_error_o
);

  logic [8:0]            pid_sr_q;
  logic                  pid_done;
  logic                  pid_ok;
  logic                  pay_bit;
  usb_rx_pkg::pkt_kind_e kind;
  logic [3:0]            len_q;
  logic                  len16_q;
  logic                  tok_last;
  logic [10:0]           tok_q;
  logic [8:0]            byte_sr_q;
  logic                  crc5_ok;
  logic                  crc16_ok;
  logic                  len_token_ok;
  logic                  len_data_ok;
  logic                  len_hs_ok;

  //////////////////////////////////////////////////////////////////////
  // PID and length
  //////////////////////////////////////////////////////////////////////

  // the PID shifts in behind a sentinel, which reaches bit 0 after eight bits
  assign pid_done = pid_sr_q[0];
  assign pid_ok   = (pid_sr_q[4:1] == ~pid_sr_q[8:5]);
  assign kind     = usb_rx_pkg::pkt_kind_e'(pid_sr_q[2:1]);
  assign pay_bit  = bit_valid_i && pid_done;

  // sixteenth payload bit of a token, where the CRC5 ends
  assign tok_last = pay_bit && (kind == usb_rx_pkg::KIND_TOKEN) && !len16_q && (&len_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_sr_q  <= '0;
      len_q     <= '0;
      len16_q   <= 1'b0;
      byte_sr_q <= '0;
      addr_o    <= '0;
      endp_o    <= '0;
    end else begin
      if (pkt_start_i) begin
        pid_sr_q <= 9'b1_0000_0000;
        len_q    <= '0;
        len16_q  <= 1'b0;
      end else if (bit_valid_i && !pid_done) begin
        pid_sr_q <= {bit_data_i, pid_sr_q[8:1]};
      end else if (pay_bit) begin
        // the low four bits count modulo a byte pair, len16 sticks once sixteen are in
        len_q   <= len_q + 4'd1;
        len16_q <= len16_q | (&len_q);
      end
      // data bytes travel behind their own sentinel, and the two CRC16
      // bytes at the end of a data packet come out as bytes as well
      if (pkt_start_i || byte_sr_q[0]) begin
        byte_sr_q <= 9'b1_0000_0000;
      end else if (pay_bit && (kind == usb_rx_pkg::KIND_DATA)) begin
        byte_sr_q <= {bit_data_i, byte_sr_q[8:1]};
      end
      if (tok_last) begin
        addr_o <= tok_q[6:0];
        endp_o <= tok_q[10:7];
      end
    end
  end

  // the first eleven token bits hold the address and then the endpoint
  always_ff @(posedge clk_i) begin
    if (pay_bit && (kind == usb_rx_pkg::KIND_TOKEN) && !len16_q && (len_q < 4'd11)) begin
      tok_q <= {bit_data_i, tok_q[10:1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CRC checks and verdict
  //////////////////////////////////////////////////////////////////////

  usb_rx_crc_check #(
    .crc_t   (usb_rx_pkg::crc5_t),
    .POLY    (`USB_RX_CRC5_POLY),
    .RESIDUE (`USB_RX_CRC5_RESIDUE)
  ) u_crc5 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .init_i       (pkt_start_i),
    .bit_valid_i  (pay_bit),
    .bit_data_i   (bit_data_i),
    .residue_ok_o (crc5_ok)
  );

  usb_rx_crc_check #(
    .crc_t   (usb_rx_pkg::crc16_t),
    .POLY    (`USB_RX_CRC16_POLY),
    .RESIDUE (`USB_RX_CRC16_RESIDUE)
  ) u_crc16 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .init_i       (pkt_start_i),
    .bit_valid_i  (pay_bit),
    .bit_data_i   (bit_data_i),
    .residue_ok_o (crc16_ok)
  );

  // token payload is exactly sixteen bits, data is whole bytes with at
  // least the CRC16, and a handshake carries nothing after its PID
  assign len_token_ok = len16_q && (len_q == 4'd0);
  assign len_data_ok  = len16_q && (len_q[2:0] == 3'd0);
  assign len_hs_ok    = !len16_q && (len_q == 4'd0);

  assign valid_packet_o = pid_ok && !stuff_err_i &&
                          (((kind == usb_rx_pkg::KIND_TOKEN) && len_token_ok && crc5_ok) ||
                           ((kind == usb_rx_pkg::KIND_DATA) && len_data_ok && crc16_ok) ||
                           ((kind == usb_rx_pkg::KIND_HANDSHAKE) && len_hs_ok));

  // error outputs are single pulses in the pkt_end cycle
  assign crc5_error_o     = pkt_end_i && (kind == usb_rx_pkg::KIND_TOKEN) && !crc5_ok;
  assign crc16_error_o    = pkt_end_i && (kind == usb_rx_pkg::KIND_DATA) && !crc16_ok;
  assign pid_error_o      = pkt_end_i && !pid_ok;
  assign bitstuff_error_o = pkt_end_i && stuff_err_i;

  assign valid_pid_o   = pid_ok;
  assign pid_o         = usb_rx_pkg::pid_e'(pid_sr_q[4:1]);
  assign rx_data_put_o = byte_sr_q[0];
  assign rx_data_o     = byte_sr_q[8:1];

endmodule

// ==== usb_rx_pkg.sv ====
// types shared by the stages of the full-speed USB receiver
// modules refer to them with scoped names, nothing is imported
package usb_rx_pkg;

  // recovered line state, the low two bits match the D+/D- pair
  typedef enum logic [2:0] {
    SE0 = 3'b000,
    DK  = 3'b001,
    DJ  = 3'b010,
    DT  = 3'b100
  } line_state_e;

  // the four PID bits as they arrive, least significant first
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } pid_e;

  // PID bits 1:0 give the packet kind
  typedef enum logic [1:0] {
    KIND_TOKEN     = 2'b01,
    KIND_HANDSHAKE = 2'b10,
    KIND_DATA      = 2'b11
  } pkt_kind_e;

  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

endpackage
